/* Makefile */
TOP := issue_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/issue.sv */
// Issue stage top; connect dispatch, the CDB and two ALU ports to this block
`timescale 1ns/10ps

module issue import issue_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                flush,
  // Dispatch
  input  logic [DISP_W-1:0]   dispatch_valid,
  input  logic [UOP_W-1:0]    dispatch_op  [0:DISP_W-1],
  input  logic [TAG_W-1:0]    dispatch_dst [0:DISP_W-1],
  input  logic [DATA_W-1:0]   dispatch_v1  [0:DISP_W-1],
  input  logic [TAG_W-1:0]    dispatch_q1  [0:DISP_W-1],
  input  logic                dispatch_r1  [0:DISP_W-1],
  input  logic [DATA_W-1:0]   dispatch_v2  [0:DISP_W-1],
  input  logic [TAG_W-1:0]    dispatch_q2  [0:DISP_W-1],
  input  logic                dispatch_r2  [0:DISP_W-1],
  // CDB
  input  logic [CDB_W-1:0]    cdb_valid,
  input  logic [TAG_W-1:0]    cdb_tag [0:CDB_W-1],
  input  logic [DATA_W-1:0]   cdb_val [0:CDB_W-1],
  // Status toward dispatch
  output logic                issue_ready,
  output logic [CNT_W-1:0]    free_count,
  // ALU 0
  output logic                alu0_en,
  output logic [UOP_W-1:0]    alu0_uop,
  output logic [DATA_W-1:0]   alu0_v1,
  output logic [DATA_W-1:0]   alu0_v2,
  output logic [TAG_W-1:0]    alu0_dst,
  // ALU 1
  output logic                alu1_en,
  output logic [UOP_W-1:0]    alu1_uop,
  output logic [DATA_W-1:0]   alu1_v1,
  output logic [DATA_W-1:0]   alu1_v2,
  output logic [TAG_W-1:0]    alu1_dst
);

  logic [RS_DEPTH-1:0] entry_wen;
  logic [RS_IDX_W-1:0] route_idx [0:DISP_W-1];
  logic [RS_DEPTH-1:0] busy;
  logic [RS_DEPTH-1:0] ready_mask;
  logic [RS_DEPTH-1:0] grant;
  logic [ISSUE_W-1:0]  issue_valid;
  logic [RS_IDX_W-1:0] sel_idx [0:ISSUE_W-1];

  // Crossbar outputs with one slot per entry
  logic [UOP_W-1:0]    rs_op  [0:RS_DEPTH-1];
  logic [TAG_W-1:0]    rs_dst [0:RS_DEPTH-1];
  logic [DATA_W-1:0]   rs_v1  [0:RS_DEPTH-1];
  logic [TAG_W-1:0]    rs_q1  [0:RS_DEPTH-1];
  logic                rs_r1  [0:RS_DEPTH-1];
  logic [DATA_W-1:0]   rs_v2  [0:RS_DEPTH-1];
  logic [TAG_W-1:0]    rs_q2  [0:RS_DEPTH-1];
  logic                rs_r2  [0:RS_DEPTH-1];

  rs_allocator u_alloc (
    .clk            (clk),
    .busy           (busy),
    .dispatch_valid (dispatch_valid),
    .entry_wen      (entry_wen),
    .route_idx      (route_idx),
    .issue_ready    (issue_ready)
  );

  // ==============================
  // Dispatch crossbar
  // ==============================

  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      rs_op[i]  = '0;
      rs_dst[i] = '0;
      rs_v1[i]  = '0;
      rs_q1[i]  = '0;
      rs_r1[i]  = 1'b0;
      rs_v2[i]  = '0;
      rs_q2[i]  = '0;
      rs_r2[i]  = 1'b0;
    end
    for (int l = 0; l < DISP_W; l++) begin
      if (dispatch_valid[l]) begin
        rs_op[route_idx[l]]  = dispatch_op[l];
        rs_dst[route_idx[l]] = dispatch_dst[l];
        rs_v1[route_idx[l]]  = dispatch_v1[l];
        rs_q1[route_idx[l]]  = dispatch_q1[l];
        rs_r1[route_idx[l]]  = dispatch_r1[l];
        rs_v2[route_idx[l]]  = dispatch_v2[l];
        rs_q2[route_idx[l]]  = dispatch_q2[l];
        rs_r2[route_idx[l]]  = dispatch_r2[l];
      end
    end
  end

  reservation_station u_rs (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .entry_wen  (entry_wen),
    .in_op      (rs_op),
    .in_dst     (rs_dst),
    .in_v1      (rs_v1),
    .in_q1      (rs_q1),
    .in_r1      (rs_r1),
    .in_v2      (rs_v2),
    .in_q2      (rs_q2),
    .in_r2      (rs_r2),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .cdb_val    (cdb_val),
    .grant      (grant),
    .busy       (busy),
    .ready_mask (ready_mask),
    .sel_idx_0  (sel_idx[0]),
    .sel_idx_1  (sel_idx[1]),
    .out_op_0   (alu0_uop),
    .out_op_1   (alu1_uop),
    .out_v1_0   (alu0_v1),
    .out_v1_1   (alu1_v1),
    .out_v2_0   (alu0_v2),
    .out_v2_1   (alu1_v2),
    .out_dst_0  (alu0_dst),
    .out_dst_1  (alu1_dst)
  );

  issue_select u_select (
    .ready_mask  (ready_mask),
    .grant       (grant),
    .issue_valid (issue_valid),
    .sel_idx     (sel_idx)
  );

  assign alu0_en = issue_valid[0];
  assign alu1_en = issue_valid[1];

  // Population count of the free entries
  always_comb begin
    free_count = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      free_count = free_count + CNT_W'(!busy[i]);
    end
  end

endmodule

/* design/issue_pkg.sv */
// Shared sizes for the issue stage; modules pull these in by a wildcard import
package issue_pkg;

  // ==============================
  // Lane counts
  // ==============================

  // Micro-ops accepted from dispatch per cycle
  localparam int DISP_W   = 2;
  // Micro-ops sent to the ALU ports per cycle
  localparam int ISSUE_W  = 2;
  // Result broadcasts per cycle on the CDB
  localparam int CDB_W    = 2;

  // ==============================
  // Station geometry
  // ==============================

  localparam int RS_DEPTH = 8;
  localparam int RS_IDX_W = 3;
  // Free count must hold 0..RS_DEPTH inclusive
  localparam int CNT_W    = 4;

  // ==============================
  // Payload widths
  // ==============================

  localparam int DATA_W   = 16;
  localparam int TAG_W    = 4;
  // Opaque micro-op word, never decoded here
  localparam int UOP_W    = 8;

endpackage

/* design/issue_select.sv */
// Select logic; picks up to ISSUE_W ready entries by lowest index each cycle
`timescale 1ns/10ps

module issue_select import issue_pkg::*; (
  input  logic [RS_DEPTH-1:0] ready_mask,
  output logic [RS_DEPTH-1:0] grant,
  output logic [ISSUE_W-1:0]  issue_valid,
  output logic [RS_IDX_W-1:0] sel_idx [0:ISSUE_W-1]
);

  // ==============================
  // Priority search per lane
  // ==============================

  // Each lane sees the ready set minus entries taken by lower lanes
  always_comb begin
    logic [RS_DEPTH-1:0] remaining;
    remaining   = ready_mask;
    grant       = '0;
    issue_valid = '0;
    for (int l = 0; l < ISSUE_W; l++) begin
      sel_idx[l] = '0;
    end

    for (int l = 0; l < ISSUE_W; l++) begin
      // Walk downward so the lowest hit is the last one kept
      for (int i = RS_DEPTH - 1; i >= 0; i--) begin
        if (remaining[i]) begin
          sel_idx[l]     = RS_IDX_W'(i);
          issue_valid[l] = 1'b1;
        end
      end
      if (issue_valid[l]) begin
        grant[sel_idx[l]]     = 1'b1;
        remaining[sel_idx[l]] = 1'b0;
      end
    end
  end

endmodule

/* design/reservation_station.sv */
// Reservation station entries with CDB wakeup and two ALU operand read ports
`timescale 1ns/10ps

module reservation_station import issue_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                flush,
  // Write side with one slot per entry from the crossbar
  input  logic [RS_DEPTH-1:0] entry_wen,
  input  logic [UOP_W-1:0]    in_op  [0:RS_DEPTH-1],
  input  logic [TAG_W-1:0]    in_dst [0:RS_DEPTH-1],
  input  logic [DATA_W-1:0]   in_v1  [0:RS_DEPTH-1],
  input  logic [TAG_W-1:0]    in_q1  [0:RS_DEPTH-1],
  input  logic                in_r1  [0:RS_DEPTH-1],
  input  logic [DATA_W-1:0]   in_v2  [0:RS_DEPTH-1],
  input  logic [TAG_W-1:0]    in_q2  [0:RS_DEPTH-1],
  input  logic                in_r2  [0:RS_DEPTH-1],
  // Wakeup side
  input  logic [CDB_W-1:0]    cdb_valid,
  input  logic [TAG_W-1:0]    cdb_tag [0:CDB_W-1],
  input  logic [DATA_W-1:0]   cdb_val [0:CDB_W-1],
  // Grant side
  input  logic [RS_DEPTH-1:0] grant,
  // Status
  output logic [RS_DEPTH-1:0] busy,
  output logic [RS_DEPTH-1:0] ready_mask,
  // Read side
  input  logic [RS_IDX_W-1:0] sel_idx_0,
  input  logic [RS_IDX_W-1:0] sel_idx_1,
  output logic [UOP_W-1:0]    out_op_0,
  output logic [UOP_W-1:0]    out_op_1,
  output logic [DATA_W-1:0]   out_v1_0,
  output logic [DATA_W-1:0]   out_v1_1,
  output logic [DATA_W-1:0]   out_v2_0,
  output logic [DATA_W-1:0]   out_v2_1,
  output logic [TAG_W-1:0]    out_dst_0,
  output logic [TAG_W-1:0]    out_dst_1
);

  // Entry state
  logic [RS_DEPTH-1:0] r1_q;
  logic [RS_DEPTH-1:0] r2_q;
  logic [UOP_W-1:0]    op_q  [0:RS_DEPTH-1];
  logic [TAG_W-1:0]    dst_q [0:RS_DEPTH-1];
  logic [DATA_W-1:0]   v1_q  [0:RS_DEPTH-1];
  logic [TAG_W-1:0]    q1_q  [0:RS_DEPTH-1];
  logic [DATA_W-1:0]   v2_q  [0:RS_DEPTH-1];
  logic [TAG_W-1:0]    q2_q  [0:RS_DEPTH-1];

  // Next source state after snooping the CDB
  logic [RS_DEPTH-1:0] r1_d;
  logic [RS_DEPTH-1:0] r2_d;
  logic [DATA_W-1:0]   v1_d  [0:RS_DEPTH-1];
  logic [DATA_W-1:0]   v2_d  [0:RS_DEPTH-1];

  // Returns {ready, value}; a waiting source takes the value on a tag hit
  function automatic logic [DATA_W:0] snoop(input logic              rdy,
                                            input logic [DATA_W-1:0] val,
                                            input logic [TAG_W-1:0]  tag);
    logic [DATA_W:0] res;
    res = {rdy, val};
    for (int c = 0; c < CDB_W; c++) begin
      if (!rdy && cdb_valid[c] && (cdb_tag[c] == tag)) begin
        res = {1'b1, cdb_val[c]};
      end
    end
    return res;
  endfunction

  // ==============================
  // Wakeup
  // ==============================

  // Entries being written snoop their incoming sources, so a match
  // in the dispatch cycle is not lost
  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (entry_wen[i]) begin
        {r1_d[i], v1_d[i]} = snoop(in_r1[i], in_v1[i], in_q1[i]);
        {r2_d[i], v2_d[i]} = snoop(in_r2[i], in_v2[i], in_q2[i]);
      end else begin
        {r1_d[i], v1_d[i]} = snoop(r1_q[i], v1_q[i], q1_q[i]);
        {r2_d[i], v2_d[i]} = snoop(r2_q[i], v2_q[i], q2_q[i]);
      end
    end
  end

  // ==============================
  // Entry registers
  // ==============================

  // Flush wins over both grant release and a new write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= '0;
      r1_q <= '0;
      r2_q <= '0;
    end else begin
      busy <= flush ? '0 : ((busy & ~grant) | entry_wen);
      r1_q <= r1_d;
      r2_q <= r2_d;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (entry_wen[i]) begin
        op_q[i]  <= in_op[i];
        dst_q[i] <= in_dst[i];
        q1_q[i]  <= in_q1[i];
        q2_q[i]  <= in_q2[i];
      end
      v1_q[i] <= v1_d[i];
      v2_q[i] <= v2_d[i];
    end
  end

  assign ready_mask = busy & r1_q & r2_q;

  // Operand read ports
  assign out_op_0  = op_q[sel_idx_0];
  assign out_v1_0  = v1_q[sel_idx_0];
  assign out_v2_0  = v2_q[sel_idx_0];
  assign out_dst_0 = dst_q[sel_idx_0];
  assign out_op_1  = op_q[sel_idx_1];
  assign out_v1_1  = v1_q[sel_idx_1];
  assign out_v2_1  = v2_q[sel_idx_1];
  assign out_dst_1 = dst_q[sel_idx_1];

  // ==============================
  // Checks
  // ==============================

  a_grant_ready: assert property (@(posedge clk) disable iff (!arst_n)
      (grant & ~ready_mask) == '0)
    else $error("grant issued to an entry that is not ready");

  a_write_free: assert property (@(posedge clk) disable iff (!arst_n)
      (entry_wen & busy) == '0)
    else $error("write enable aimed at a busy entry");

endmodule

/* design/rs_allocator.sv */
// Allocator for the reservation station; maps dispatch lanes to free entries
`timescale 1ns/10ps

module rs_allocator import issue_pkg::*; (
  input  logic                clk,
  input  logic [RS_DEPTH-1:0] busy,
  input  logic [DISP_W-1:0]   dispatch_valid,
  output logic [RS_DEPTH-1:0] entry_wen,
  output logic [RS_IDX_W-1:0] route_idx [0:DISP_W-1],
  output logic                issue_ready
);

  logic [CNT_W-1:0]  free_cnt;
  logic [DISP_W-1:0] lane_ok;

  // Scan upward; each free entry goes to the next lane still without one
  always_comb begin
    int taken;
    taken    = 0;
    free_cnt = '0;
    lane_ok  = '0;
    for (int l = 0; l < DISP_W; l++) begin
      route_idx[l] = '0;
    end
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (!busy[i]) begin
        free_cnt = free_cnt + 1'b1;
        for (int l = 0; l < DISP_W; l++) begin
          if (l == taken) begin
            route_idx[l] = RS_IDX_W'(i);
            lane_ok[l]   = 1'b1;
          end
        end
        taken = taken + 1;
      end
    end
  end

  // Only lanes that are valid and found an entry write
  always_comb begin
    entry_wen = '0;
    for (int l = 0; l < DISP_W; l++) begin
      if (dispatch_valid[l] && lane_ok[l]) begin
        entry_wen[route_idx[l]] = 1'b1;
      end
    end
  end

  // Room for a full dispatch group
  assign issue_ready = (free_cnt >= CNT_W'(DISP_W));

  // ==============================
  // Checks
  // ==============================

  // Dispatch source must respect the stall level seen before the edge
  a_no_dispatch_on_stall: assert property (@(posedge clk) (|dispatch_valid) |-> issue_ready)
    else $error("dispatch lane valid while issue_ready is low");

  a_lanes_distinct: assert property (@(posedge clk)
      (&dispatch_valid && issue_ready) |-> (route_idx[0] != route_idx[1]))
    else $error("both dispatch lanes routed to the same entry");

endmodule

/* dv/issue_tests.svh */
// Directed test tasks that the issue stage testbench includes inside its module
`ifndef ISSUE_TESTS_SVH
`define ISSUE_TESTS_SVH

// One micro-op on a dispatch lane with random operand values
task automatic load_lane(input int lane, input logic [UOP_W-1:0] op,
                         input logic [TAG_W-1:0] dst,
                         input logic r1, input logic [TAG_W-1:0] q1,
                         input logic r2, input logic [TAG_W-1:0] q2);
  dispatch_valid[lane] = 1'b1;
  dispatch_op[lane]    = op;
  dispatch_dst[lane]   = dst;
  dispatch_r1[lane]    = r1;
  dispatch_q1[lane]    = q1;
  dispatch_v1[lane]    = DATA_W'($random(seed));
  dispatch_r2[lane]    = r2;
  dispatch_q2[lane]    = q2;
  dispatch_v2[lane]    = DATA_W'($random(seed));
endtask

task automatic send_cdb(input int lane, input logic [TAG_W-1:0] tag,
                        input logic [DATA_W-1:0] val);
  cdb_valid[lane] = 1'b1;
  cdb_tag[lane]   = tag;
  cdb_val[lane]   = val;
endtask

task automatic reset_values();
  test_name = "reset_values";
  compare("issue_ready", 1, 32'(issue_ready));
  compare("free_count", RS_DEPTH, 32'(free_count));
  compare("alu0_en", 0, 32'(alu0_en));
  compare("alu1_en", 0, 32'(alu1_en));
  next_cycle();
endtask

task automatic dual_dispatch();
  logic [DATA_W-1:0] a1;
  logic [DATA_W-1:0] b2;
  test_name = "dual_dispatch";
  load_lane(0, 8'h11, 4'h1, 1'b1, 4'h0, 1'b1, 4'h0);
  load_lane(1, 8'h22, 4'h2, 1'b1, 4'h0, 1'b1, 4'h0);
  a1 = dispatch_v1[0];
  b2 = dispatch_v2[1];
  next_cycle();
  // One cycle after the write both ALUs fire
  compare("alu0_uop", 32'h11, 32'(alu0_uop));
  compare("alu0_v1", 32'(a1), 32'(alu0_v1));
  compare("alu1_uop", 32'h22, 32'(alu1_uop));
  compare("alu1_v2", 32'(b2), 32'(alu1_v2));
  compare("alu1_dst", 2, 32'(alu1_dst));
  next_cycle();
  compare("free_count", RS_DEPTH, 32'(free_count));
endtask

task automatic tag_wakeup();
  logic [DATA_W-1:0] val;
  test_name = "tag_wakeup";
  load_lane(0, 8'h33, 4'h3, 1'b1, 4'h0, 1'b0, 4'h5);
  repeat (3) begin
    next_cycle();
    compare("alu0_en", 0, 32'(alu0_en));
  end
  val = DATA_W'($random(seed));
  send_cdb(0, 4'h5, val);
  next_cycle();
  compare("alu0_en", 1, 32'(alu0_en));
  compare("alu0_v2", 32'(val), 32'(alu0_v2));
  next_cycle();
  // Broadcast lands in the dispatch cycle itself
  load_lane(0, 8'h44, 4'h4, 1'b0, 4'h6, 1'b1, 4'h0);
  val = DATA_W'($random(seed));
  send_cdb(1, 4'h6, val);
  next_cycle();
  compare("alu0_en", 1, 32'(alu0_en));
  compare("alu0_v1", 32'(val), 32'(alu0_v1));
  next_cycle();
endtask

task automatic priority_order();
  test_name = "priority_order";
  load_lane(0, 8'h50, 4'h0, 1'b0, 4'h7, 1'b1, 4'h0);
  load_lane(1, 8'h51, 4'h1, 1'b0, 4'h7, 1'b1, 4'h0);
  next_cycle();
  load_lane(0, 8'h52, 4'h2, 1'b0, 4'h7, 1'b1, 4'h0);
  load_lane(1, 8'h53, 4'h3, 1'b0, 4'h7, 1'b1, 4'h0);
  next_cycle();
  send_cdb(0, 4'h7, DATA_W'($random(seed)));
  next_cycle();
  compare("alu0_uop", 32'h50, 32'(alu0_uop));
  compare("alu1_uop", 32'h51, 32'(alu1_uop));
  next_cycle();
  compare("alu0_uop", 32'h52, 32'(alu0_uop));
  compare("alu1_uop", 32'h53, 32'(alu1_uop));
  next_cycle();
  compare("free_count", RS_DEPTH, 32'(free_count));
endtask

task automatic fill_until_stall();
  test_name = "fill_until_stall";
  repeat (3) begin
    load_lane(0, 8'h60, 4'h8, 1'b0, 4'h9, 1'b1, 4'h0);
    load_lane(1, 8'h61, 4'h8, 1'b0, 4'h9, 1'b1, 4'h0);
    next_cycle();
  end
  compare("issue_ready", 1, 32'(issue_ready));
  load_lane(0, 8'h62, 4'h8, 1'b0, 4'h9, 1'b1, 4'h0);
  next_cycle();
  compare("issue_ready", 0, 32'(issue_ready));
  compare("free_count", 1, 32'(free_count));
endtask

task automatic flush_all();
  test_name = "flush_all";
  flush = 1'b1;
  next_cycle();
  compare("free_count", RS_DEPTH, 32'(free_count));
  compare("issue_ready", 1, 32'(issue_ready));
  // The tag the flushed entries waited on must wake nothing
  send_cdb(0, 4'h9, DATA_W'($random(seed)));
  repeat (2) begin
    next_cycle();
    compare("alu0_en", 0, 32'(alu0_en));
    compare("alu1_en", 0, 32'(alu1_en));
  end
endtask

`endif

/* dv/issue_tb.sv */
// Testbench top for the issue stage; compile with the RTL and run issue_tb as the top module
`timescale 1ns/10ps

module issue_tb import issue_pkg::*; ();

  localparam int MAX_CYCLES = 400;

  logic                clk;
  logic                arst_n;
  logic                flush;
  logic [DISP_W-1:0]   dispatch_valid;
  logic [UOP_W-1:0]    dispatch_op  [0:DISP_W-1];
  logic [TAG_W-1:0]    dispatch_dst [0:DISP_W-1];
  logic [DATA_W-1:0]   dispatch_v1  [0:DISP_W-1];
  logic [TAG_W-1:0]    dispatch_q1  [0:DISP_W-1];
  logic                dispatch_r1  [0:DISP_W-1];
  logic [DATA_W-1:0]   dispatch_v2  [0:DISP_W-1];
  logic [TAG_W-1:0]    dispatch_q2  [0:DISP_W-1];
  logic                dispatch_r2  [0:DISP_W-1];
  logic [CDB_W-1:0]    cdb_valid;
  logic [TAG_W-1:0]    cdb_tag [0:CDB_W-1];
  logic [DATA_W-1:0]   cdb_val [0:CDB_W-1];
  logic                issue_ready;
  logic [CNT_W-1:0]    free_count;
  logic                alu0_en;
  logic [UOP_W-1:0]    alu0_uop;
  logic [DATA_W-1:0]   alu0_v1;
  logic [DATA_W-1:0]   alu0_v2;
  logic [TAG_W-1:0]    alu0_dst;
  logic                alu1_en;
  logic [UOP_W-1:0]    alu1_uop;
  logic [DATA_W-1:0]   alu1_v1;
  logic [DATA_W-1:0]   alu1_v2;
  logic [TAG_W-1:0]    alu1_dst;

  int    errors;
  int    cycles;
  int    seed;
  string test_name;

  // Reference copy of the entries
  logic [RS_DEPTH-1:0] m_busy;
  logic [RS_DEPTH-1:0] m_r1;
  logic [RS_DEPTH-1:0] m_r2;
  logic [UOP_W-1:0]    m_op  [0:RS_DEPTH-1];
  logic [TAG_W-1:0]    m_dst [0:RS_DEPTH-1];
  logic [DATA_W-1:0]   m_v1  [0:RS_DEPTH-1];
  logic [TAG_W-1:0]    m_q1  [0:RS_DEPTH-1];
  logic [DATA_W-1:0]   m_v2  [0:RS_DEPTH-1];
  logic [TAG_W-1:0]    m_q2  [0:RS_DEPTH-1];
  // Picks predicted for the current cycle
  logic [ISSUE_W-1:0]  p_en;
  int                  p_sel [0:ISSUE_W-1];

  issue uut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Verification failed");
    $finish;
  end

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else begin
        errors++;
        $display("[FAIL] %s %s expected %0h actual %0h", test_name, what, exp, act);
      end
  endtask

  task automatic check_alu(input int lane, input logic en, input logic [UOP_W-1:0] uop,
                           input logic [DATA_W-1:0] v1, input logic [DATA_W-1:0] v2,
                           input logic [TAG_W-1:0] dst);
    int e;
    e = p_sel[lane];
    compare($sformatf("alu%0d_en", lane), 32'(p_en[lane]), 32'(en));
    if (p_en[lane] && en) begin
      compare($sformatf("alu%0d_uop", lane), 32'(m_op[e]), 32'(uop));
      compare($sformatf("alu%0d_v1", lane), 32'(m_v1[e]), 32'(v1));
      compare($sformatf("alu%0d_v2", lane), 32'(m_v2[e]), 32'(v2));
      compare($sformatf("alu%0d_dst", lane), 32'(m_dst[e]), 32'(dst));
    end
  endtask

  // ==============================
  // Reference model
  // ==============================

  // Lowest-index select over ready entries, then compare every port
  task automatic check_ports();
    int free;
    int lane;
    free = 0;
    lane = 0;
    p_en = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (!m_busy[i]) begin
        free++;
      end else if (m_r1[i] && m_r2[i] && lane < ISSUE_W) begin
        p_sel[lane] = i;
        p_en[lane]  = 1'b1;
        lane++;
      end
    end
    compare("free_count", free, 32'(free_count));
    compare("issue_ready", 32'(free >= DISP_W), 32'(issue_ready));
    check_alu(0, alu0_en, alu0_uop, alu0_v1, alu0_v2, alu0_dst);
    check_alu(1, alu1_en, alu1_uop, alu1_v1, alu1_v2, alu1_dst);
  endtask

  // Applies one clock edge with the inputs that were seen before it
  task automatic update_model();
    int slot [0:DISP_W-1];
    int found;
    found = 0;
    for (int l = 0; l < DISP_W; l++) begin
      slot[l] = -1;
    end
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (!m_busy[i] && found < DISP_W) begin
        slot[found] = i;
        found++;
      end
    end
    for (int l = 0; l < ISSUE_W; l++) begin
      if (p_en[l]) begin
        m_busy[p_sel[l]] = 1'b0;
      end
    end
    for (int l = 0; l < DISP_W; l++) begin
      if (dispatch_valid[l] && slot[l] >= 0) begin
        m_busy[slot[l]] = 1'b1;
        m_op[slot[l]]   = dispatch_op[l];
        m_dst[slot[l]]  = dispatch_dst[l];
        m_r1[slot[l]]   = dispatch_r1[l];
        m_v1[slot[l]]   = dispatch_v1[l];
        m_q1[slot[l]]   = dispatch_q1[l];
        m_r2[slot[l]]   = dispatch_r2[l];
        m_v2[slot[l]]   = dispatch_v2[l];
        m_q2[slot[l]]   = dispatch_q2[l];
      end
    end
    // New entries snoop too, so a same-cycle broadcast is caught
    for (int c = 0; c < CDB_W; c++) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (cdb_valid[c] && !m_r1[i] && m_q1[i] == cdb_tag[c]) begin
          m_r1[i] = 1'b1;
          m_v1[i] = cdb_val[c];
        end
        if (cdb_valid[c] && !m_r2[i] && m_q2[i] == cdb_tag[c]) begin
          m_r2[i] = 1'b1;
          m_v2[i] = cdb_val[c];
        end
      end
    end
    if (flush) begin
      m_busy = '0;
    end
  endtask

  task automatic idle_inputs();
    flush          = 1'b0;
    dispatch_valid = '0;
    cdb_valid      = '0;
    for (int l = 0; l < DISP_W; l++) begin
      dispatch_op[l]  = '0;
      dispatch_dst[l] = '0;
      dispatch_v1[l]  = '0;
      dispatch_q1[l]  = '0;
      dispatch_r1[l]  = 1'b0;
      dispatch_v2[l]  = '0;
      dispatch_q2[l]  = '0;
      dispatch_r2[l]  = 1'b0;
    end
    for (int c = 0; c < CDB_W; c++) begin
      cdb_tag[c] = '0;
      cdb_val[c] = '0;
    end
  endtask

  // Check mid-cycle, step the model past the edge, then drop the strobes
  task automatic next_cycle();
    @(negedge clk);
    check_ports();
    @(posedge clk);
    #1;
    update_model();
    idle_inputs();
  endtask

  `include "issue_tests.svh"

  initial begin
    seed      = 69807;
    errors    = 0;
    test_name = "reset";
    arst_n    = 1'b0;
    m_busy    = '0;
    m_r1      = '0;
    m_r2      = '0;
    p_en      = '0;
    idle_inputs();
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    reset_values();
    dual_dispatch();
    tag_wakeup();
    priority_order();
    fill_until_stall();
    flush_all();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+dv
design/issue_pkg.sv
design/rs_allocator.sv
design/reservation_station.sv
design/issue_select.sv
design/issue.sv
dv/issue_tb.sv
